// File: rtl/dlx_defines.svh
`ifndef DLX_DEFINES_SVH
`define DLX_DEFINES_SVH

// Datapath and address width
`define DLX_XLEN     32
`define DLX_PC_STEP  32'd4           // One instruction word per step

// Field widths of the instruction word
`define DLX_OPC_W    6
`define DLX_REG_W    5
`define DLX_NAME_W   26              // J-format offset
`define DLX_IMM_W    16              // I-format immediate

`define DLX_RESET_PC 32'h0000_0100   // First fetch address
`define DLX_LINK_REG 5'd31           // jal writes its return address here

// Control-flow opcodes, everything else falls through
`define DLX_OP_J     6'h02
`define DLX_OP_JAL   6'h03
`define DLX_OP_BEQZ  6'h04
`define DLX_OP_BNEZ  6'h05
`define DLX_OP_JR    6'h12

`endif

// File: rtl/dlxPkg.sv
`include "dlx_defines.svh"

package dlxPkg;

	// J-format word, used by j and jal
	typedef struct packed {
		logic [`DLX_OPC_W-1:0]  opcode; // Bits 31:26
		logic [`DLX_NAME_W-1:0] name;   // Signed byte offset from PC+4
	} jTypeT;

	// I-format word, used by jr, beqz and bnez
	typedef struct packed {
		logic [`DLX_OPC_W-1:0] opcode; // Same position as in J-format
		logic [`DLX_REG_W-1:0] rs;     // Source register, value arrives as rs1
		logic [`DLX_REG_W-1:0] rt;     // Unused by the flow unit
		logic [`DLX_IMM_W-1:0] imm;    // Signed branch offset
	} iTypeT;

	// One fetched word, seen either way
	// The opcode lands on the same bits in both views
	typedef union packed {
		jTypeT j;
		iTypeT i;
	} instrWordT;

	// How the next PC is chosen
	typedef enum logic [1:0] {
		flowSeq    = 2'd0, // PC+4, also untaken branches
		flowJump   = 2'd1, // j and jal
		flowBranch = 2'd2, // Taken beqz or bnez
		flowReg    = 2'd3  // jr
	} flowKindT;

	// Candidate targets, all formed every cycle
	typedef struct packed {
		logic [`DLX_XLEN-1:0] jumpTarget;   // PC+4 plus extended name
		logic [`DLX_XLEN-1:0] branchTarget; // PC+4 plus extended imm
		logic [`DLX_XLEN-1:0] regTarget;    // Straight from rs1
	} targetSetT;

	// Output of the condition evaluator
	typedef struct packed {
		flowKindT kind; // Selects one of the targets above
		logic     link; // Only jal
	} flowDecT;

	// Link register write toward the register file
	// A single-cycle pulse, no handshake
	typedef struct packed {
		logic                  write;  // Pulse
		logic [`DLX_REG_W-1:0] regIdx; // Always r31
		logic [`DLX_XLEN-1:0]  value;  // Return address
	} linkT;

endpackage

// File: rtl/targetCalc.sv
`include "dlx_defines.svh"

module targetCalc import dlxPkg::*; (
	input  instrWordT            instr,
	input  logic [`DLX_XLEN-1:0] pcPlusFour,
	input  logic [`DLX_XLEN-1:0] rs1,
	output targetSetT            targets
);

	// Raw offset fields, one per view of the word
	logic [`DLX_NAME_W-1:0] name;
	logic [`DLX_IMM_W-1:0]  imm;

	// Offsets widened to the datapath
	logic [`DLX_XLEN-1:0] nameExt;
	logic [`DLX_XLEN-1:0] immExt;

	assign name = instr.j.name; // J view
	assign imm  = instr.i.imm;  // I view

	// Sign extension, replicate the top bit
	assign nameExt = {{(`DLX_XLEN-`DLX_NAME_W){name[`DLX_NAME_W-1]}}, name};
	assign immExt  = {{(`DLX_XLEN-`DLX_IMM_W){imm[`DLX_IMM_W-1]}}, imm};

	// All three candidates are always valid
	// The opcode decides later which one is used
	always_comb begin
		targets.jumpTarget   = pcPlusFour + nameExt; // Wraps mod 2^32
		targets.branchTarget = pcPlusFour + immExt;  // Negative offsets go backward
		targets.regTarget    = rs1;                  // jr, no alignment check
	end

endmodule

// File: rtl/conditionEval.sv
`include "dlx_defines.svh"

module conditionEval import dlxPkg::*; (
	input  instrWordT            instr,
	input  logic [`DLX_XLEN-1:0] rs1,
	output flowDecT              decision
);

	logic [`DLX_OPC_W-1:0] opcode;
	logic                  rs1Zero; // Shared by both branch types

	assign opcode  = instr.i.opcode;       // Same bits as instr.j.opcode
	assign rs1Zero = (rs1 == '0);

	always_comb begin
		// Defaults cover all other opcodes
		decision.kind = flowSeq;
		decision.link = 1'b0;

		case (opcode)
			`DLX_OP_J: begin
				decision.kind = flowJump;
			end
			`DLX_OP_JAL: begin
				decision.kind = flowJump; // Same target as j
				decision.link = 1'b1;     // Plus return address to r31
			end
			`DLX_OP_JR: begin
				decision.kind = flowReg;
			end
			`DLX_OP_BEQZ: begin
				// Taken when rs1 is zero
				if (rs1Zero) begin
					decision.kind = flowBranch;
				end
			end
			`DLX_OP_BNEZ: begin
				if (!rs1Zero) begin
					decision.kind = flowBranch; // Taken when rs1 nonzero
				end
			end
			default: begin
				decision.kind = flowSeq; // Not a control-flow instruction
			end
		endcase
	end

endmodule

// File: rtl/pcSequencer.sv
`include "dlx_defines.svh"

module pcSequencer import dlxPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 step,       // Advance strobe, one instruction per high cycle
	input  flowDecT              decision,
	input  targetSetT            targets,
	output logic [`DLX_XLEN-1:0] pc,
	output logic [`DLX_XLEN-1:0] pcPlusFour,
	output linkT                 link
);

	logic [`DLX_XLEN-1:0] pcReg;
	logic [`DLX_XLEN-1:0] nextPc;

	// Link write state, register index is constant
	logic                 linkWrite;
	logic [`DLX_XLEN-1:0] linkValue;

	assign pc         = pcReg;
	assign pcPlusFour = pcReg + `DLX_PC_STEP; // Wraps at the top of memory

	// Target select
	always_comb begin
		case (decision.kind)
			flowJump:   nextPc = targets.jumpTarget;
			flowBranch: nextPc = targets.branchTarget;
			flowReg:    nextPc = targets.regTarget;
			default:    nextPc = pcPlusFour; // flowSeq
		endcase
	end

	// PC register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcReg <= `DLX_RESET_PC;
		end else if (step) begin
			pcReg <= nextPc;
		end
	end

	// Link pulse, high for one cycle after a jal step
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			linkWrite <= 1'b0;
			linkValue <= '0;
		end else if (step) begin
			linkWrite <= decision.link;
			linkValue <= pcPlusFour; // PC+4 of the stepping instruction
		end else begin
			linkWrite <= 1'b0; // Drop the pulse, value is kept
		end
	end

	assign link = '{
		write:  linkWrite,
		regIdx: `DLX_LINK_REG,
		value:  linkValue
	};

endmodule

// File: rtl/dlxFlowUnit.sv
`include "dlx_defines.svh"

module dlxFlowUnit import dlxPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 step,  // One instruction per high cycle
	input  instrWordT            instr, // Valid with step
	input  logic [`DLX_XLEN-1:0] rs1,   // Valid with step
	output logic [`DLX_XLEN-1:0] pc,
	output linkT                 link   // r31 write pulse from jal
);

	// Internal nets between the three blocks
	logic [`DLX_XLEN-1:0] pcPlusFour;
	targetSetT            targets;
	flowDecT              decision;

	// Candidate targets from the current PC
	targetCalc u_targetCalc (
		.instr      (instr),
		.pcPlusFour (pcPlusFour),
		.rs1        (rs1),
		.targets    (targets)
	);

	// Opcode decode and zero test, in parallel with the adders
	conditionEval u_conditionEval (
		.instr    (instr),
		.rs1      (rs1),
		.decision (decision)
	);

	// PC and link registers
	pcSequencer u_pcSequencer (
		.clk        (clk),
		.rstN       (rstN),
		.step       (step),
		.decision   (decision),
		.targets    (targets),
		.pc         (pc),
		.pcPlusFour (pcPlusFour),
		.link       (link)
	);

endmodule

// File: tests/tbClock.sv
module tbClock (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod  = 10; // 20 ns clock
	localparam int resetCycles = 5;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rstN = 1'b1;
		#1 rstN = 1'b0; // Clean falling edge so the async reset fires before the first clock
		repeat (resetCycles) @(posedge clk);
		#2 rstN = 1'b1; // Released with the same skew as the other inputs
	end

endmodule

// File: tests/flowChecker.sv
`include "dlx_defines.svh"

module flowChecker import dlxPkg::*; (
	input logic                 clk,
	input logic                 rstN,
	input logic                 step,
	input logic [`DLX_XLEN-1:0] pc,
	input linkT                 link
);
	timeunit 1ns;
	timeprecision 100ps;

	int assertFails = 0; // Read by the testbench at the end of the run

	// Back-to-back pulses need a stepping edge for each of them
	linkPulseSingle: assert property (@(posedge clk) disable iff (!rstN)
		(link.write && $past(link.write)) |-> ($past(step) && $past(step, 2)))
		else begin
			assertFails++;
			$error("link.write high on two cycles without a step on both edges");
		end

	// No step, no PC change
	pcHoldIdle: assert property (@(posedge clk) disable iff (!rstN)
		!step |=> $stable(pc))
		else begin
			assertFails++;
			$error("pc changed after a cycle with step low");
		end

	pcInReset: assert property (@(posedge clk)
		!rstN |-> (pc == `DLX_RESET_PC)) // Async reset, so already true at the first edge
		else begin
			assertFails++;
			$error("pc not at the reset address while rstN is low");
		end

endmodule

// File: tests/tbDlxFlow.sv
`include "dlx_defines.svh"

module tbDlxFlow import dlxPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod      = 20;
	localparam int resetCycles    = 6;   // Five in reset plus the release cycle
	localparam int directedCycles = 60;  // Upper bound over the directed tasks
	localparam int randomSteps    = 200;
	localparam int marginNs       = 1000;
	// Each random step may be followed by one idle cycle
	localparam int watchdogNs =
		(resetCycles + directedCycles + 2 * randomSteps) * clkPeriod + marginNs;
	localparam logic [15:0] lfsrSeed = 16'd36682;

	logic                 clk;
	logic                 rstN;
	logic                 step;
	instrWordT            instr;
	logic [`DLX_XLEN-1:0] rs1;
	logic [`DLX_XLEN-1:0] pc;
	linkT                 link;

	// Reference state
	logic [`DLX_XLEN-1:0] modelPc;
	linkT                 modelLink;
	logic [15:0]          lfsrState;

	tbClock u_clock (
		.clk  (clk),
		.rstN (rstN)
	);

	dlxFlowUnit u_dut (
		.clk   (clk),
		.rstN  (rstN),
		.step  (step),
		.instr (instr),
		.rs1   (rs1),
		.pc    (pc),
		.link  (link)
	);

	bind dlxFlowUnit flowChecker u_flowChecker (
		.clk  (clk),
		.rstN (rstN),
		.step (step),
		.pc   (pc),
		.link (link)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per returned bit with the newest in the LSB
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic instrWordT jWord(input logic [5:0] opc, input logic [25:0] name);
		instrWordT w;
		w.j.opcode = opc;
		w.j.name   = name;
		return w;
	endfunction

	function automatic instrWordT iWord(input logic [5:0] opc, input logic [15:0] imm);
		instrWordT w;
		w.i.opcode = opc;
		w.i.rs     = 5'd7; // Register number is not used by the unit
		w.i.rt     = 5'd0;
		w.i.imm    = imm;
		return w;
	endfunction

	task automatic comparePc(input logic [`DLX_XLEN-1:0] exp, input string what);
		if (pc !== exp) begin
			$display("mismatch pc (%s): got %h expected %h", what, pc, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	task automatic compareLink(input linkT exp, input string what);
		if (link !== exp) begin
			$display("mismatch link (%s): got write=%h reg=%h value=%h", what,
				link.write, link.regIdx, link.value);
			$display("  expected write=%h reg=%h value=%h",
				exp.write, exp.regIdx, exp.value);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	// Step low for n edges while the PC holds and the pulse drops
	task automatic idleCycles(input int n);
		step = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#2;
			modelLink.write = 1'b0; // Value keeps the last return address
			comparePc(modelPc, "idle");
			compareLink(modelLink, "idle");
		end
	endtask

	// One stepping cycle from 2 ns after an edge to 2 ns after the next
	task automatic stepOnce(input instrWordT w, input logic [`DLX_XLEN-1:0] r,
		input string what);
		logic [`DLX_XLEN-1:0] seqPc;
		logic [`DLX_XLEN-1:0] nextPc;
		logic                 isJal;
		seqPc  = modelPc + 32'd4; // Wraps past the top
		nextPc = seqPc;
		isJal  = 1'b0;
		case (w.j.opcode)
			`DLX_OP_J: nextPc = seqPc + 32'($signed(w.j.name));
			`DLX_OP_JAL: begin
				nextPc = seqPc + 32'($signed(w.j.name));
				isJal  = 1'b1;
			end
			`DLX_OP_JR: nextPc = r;
			`DLX_OP_BEQZ: begin
				if (r == 32'd0) begin
					nextPc = seqPc + 32'($signed(w.i.imm));
				end
			end
			`DLX_OP_BNEZ: begin
				if (r != 32'd0) begin
					nextPc = seqPc + 32'($signed(w.i.imm));
				end
			end
			default: nextPc = seqPc; // Not control flow
		endcase
		step  = 1'b1;
		instr = w;
		rs1   = r;
		@(posedge clk);
		#2;
		step  = 1'b0; // Next call may raise it again in the same time step
		instr = '0;
		rs1   = '0;
		modelPc         = nextPc;
		modelLink.write = isJal;
		modelLink.value = seqPc; // Every step records its PC+4
		comparePc(modelPc, what);
		compareLink(modelLink, what);
	endtask

	task automatic resetAndIdle();
		comparePc(`DLX_RESET_PC, "after reset");
		compareLink(modelLink, "after reset");
		idleCycles(4);
	endtask

	task automatic sequentialFlow();
		stepOnce(jWord(6'h00, 26'h000_0000), 32'd0, "opcode 00");
		stepOnce(jWord(6'h23, 26'h3ff_ffff), 32'h0000_0005, "opcode 23");
		stepOnce(iWord(6'h08, 16'hffff), 32'hffff_ffff, "opcode 08");
		stepOnce(jWord(6'h3f, 26'h155_5555), 32'd0, "opcode 3f");
		idleCycles(2);
	endtask

	task automatic jumpsAndLinks();
		stepOnce(jWord(`DLX_OP_J, 26'h000_0040), 32'd0, "j forward");
		stepOnce(jWord(`DLX_OP_J, 26'h3ff_fff0), 32'd0, "j backward");
		stepOnce(jWord(`DLX_OP_JAL, 26'h000_0100), 32'd0, "jal forward");
		idleCycles(1); // Pulse lasts one cycle
		stepOnce(jWord(`DLX_OP_JAL, 26'h200_0000), 32'd0, "jal most negative");
		stepOnce(jWord(`DLX_OP_JAL, 26'h000_0000), 32'd0, "jal back to back");
		stepOnce(jWord(`DLX_OP_J, 26'h000_0008), 32'd0, "j after jal");
		idleCycles(1);
	endtask

	task automatic registerJumps();
		stepOnce(iWord(`DLX_OP_JR, 16'h0000), 32'h0000_2000, "jr");
		stepOnce(iWord(`DLX_OP_JR, 16'h1234), 32'hffff_fffc, "jr top word");
		stepOnce(jWord(6'h00, 26'h000_0000), 32'd0, "seq wraps to zero");
		stepOnce(iWord(`DLX_OP_JR, 16'hffff), 32'h1234_5679, "jr odd address");
		stepOnce(iWord(`DLX_OP_JR, 16'h0000), 32'd0, "jr to zero");
		idleCycles(1);
	endtask

	task automatic conditionalBranches();
		stepOnce(iWord(`DLX_OP_BEQZ, 16'h0008), 32'd0, "beqz taken");
		stepOnce(iWord(`DLX_OP_BEQZ, 16'h0008), 32'd5, "beqz untaken");
		stepOnce(iWord(`DLX_OP_BEQZ, 16'hfffc), 32'd0, "beqz taken backward");
		stepOnce(iWord(`DLX_OP_BNEZ, 16'h0010), 32'd0, "bnez untaken");
		stepOnce(iWord(`DLX_OP_BNEZ, 16'hffe0), 32'h8000_0000, "bnez taken backward");
		stepOnce(iWord(`DLX_OP_BNEZ, 16'h8000), 32'd1, "bnez most negative");
		stepOnce(iWord(`DLX_OP_BEQZ, 16'h8000), 32'hffff_ffff, "beqz untaken negative");
		idleCycles(1);
	endtask

	// Five of eight picks are control flow and the rest any opcode
	task automatic randomProgram();
		instrWordT            w;
		logic [31:0]          bits;
		logic [`DLX_XLEN-1:0] r;
		logic [5:0]           opc;
		for (int n = 0; n < randomSteps; n++) begin
			bits = randBits(3);
			case (bits[2:0])
				3'd0: opc = `DLX_OP_J;
				3'd1: opc = `DLX_OP_JAL;
				3'd2: opc = `DLX_OP_JR;
				3'd3: opc = `DLX_OP_BEQZ;
				3'd4: opc = `DLX_OP_BNEZ;
				default: begin
					bits = randBits(6);
					opc  = bits[5:0];
				end
			endcase
			bits = randBits(26);
			w    = jWord(opc, bits[25:0]); // Same bits give the I view
			bits = randBits(1);
			if (bits[0]) begin
				r = randBits(32);
			end else begin
				r = '0; // Zero often enough to take beqz
			end
			stepOnce(w, r, "random");
			bits = randBits(2);
			if (bits[1:0] == 2'd0) begin
				idleCycles(1);
			end
		end
	endtask

	initial begin
		#(watchdogNs);
		$display("Timeout: the tests did not finish within %0d ns", watchdogNs);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// A failing checker assertion ends the run at once
	initial begin
		wait (u_dut.u_flowChecker.assertFails != 0);
		$display("A checker assertion failed, see the error above");
		$display("SOME TESTS FAILED");
		$fatal(1, "checker assertion failed");
	end

	initial begin
		step      = 1'b0;
		instr     = '0;
		rs1       = '0;
		lfsrState = lfsrSeed;
		modelPc   = `DLX_RESET_PC;
		modelLink = '{write: 1'b0, regIdx: `DLX_LINK_REG, value: 32'd0};
		@(posedge clk); // Reset is low by now
		wait (rstN === 1'b1);
		@(posedge clk);
		#2;
		resetAndIdle();
		sequentialFlow();
		jumpsAndLinks();
		registerJumps();
		conditionalBranches();
		randomProgram();
		idleCycles(2);
		if (u_dut.u_flowChecker.assertFails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("Assertion failures in the checker: %0d",
				u_dut.u_flowChecker.assertFails);
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+rtl
rtl/dlxPkg.sv
rtl/targetCalc.sv
rtl/conditionEval.sv
rtl/pcSequencer.sv
rtl/dlxFlowUnit.sv
tests/tbClock.sv
tests/flowChecker.sv
tests/tbDlxFlow.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the flow unit testbench with Verilator, run it, judge the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=simDlxFlow
LOG=sim.log
PASS_MSG="ALL TESTS PASSED"

verilator --binary --timing --assert \
	-f files.f \
	--top-module tbDlxFlow \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

# Keep running after an assertion error so the testbench can report it
"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail, see $LOG"
	exit 1
fi
